// File: rtl/device_info_params.svh
`ifndef DEVICE_INFO_PARAMS_SVH
`define DEVICE_INFO_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bus widths

// APB byte address
`define DEVINFO_ADDR_WIDTH 8

// APB data and ICAP data, both fixed at one word
`define DEVINFO_DATA_WIDTH 32

////////////////////////////////////////////////////////////
// Boot timing

// Clocks to wait after reset before touching ICAP
// Short value for simulation, hardware builds redefine it
`define DEVINFO_BOOT_HOLD 64

////////////////////////////////////////////////////////////
// ICAP command words, unreversed

// Bus width detect / sync
`define ICAP_WORD_SYNC      32'hAA99_5566
// Type 1 NOP
`define ICAP_WORD_NOP       32'h2000_0000
// Type 1 read, IDCODE register, one word
`define ICAP_WORD_RD_IDCODE 32'h2801_8001
// Type 1 write, CMD register, one word
`define ICAP_WORD_WR_CMD    32'h3000_8001
// CMD register value for DESYNC
`define ICAP_WORD_DESYNC    32'h0000_000D

`endif

// File: rtl/device_info_pkg.sv
`include "device_info_params.svh"

package device_info_pkg;

	////////////////////////////////////////////////////////////
	// APB register map

	// Register offsets, one word apart
	// Same width as the APB address so a case on paddr lines up
	typedef enum logic [`DEVINFO_ADDR_WIDTH-1:0] {
		// Bit 0 is the IDCODE valid flag
		REG_STATUS = `DEVINFO_ADDR_WIDTH'h0,
		// Device IDCODE as read over ICAP
		REG_IDCODE = `DEVINFO_ADDR_WIDTH'h4
	} regid_t;

	////////////////////////////////////////////////////////////
	// ICAP sequencer

	typedef enum logic [2:0] {
		// Waiting for the boot timer
		BOOT_HOLD = 3'h0,
		// Sync word goes out
		SYNC      = 3'h1,
		// Two NOPs after sync
		NOP       = 3'h2,
		// IDCODE read header
		HEADER    = 3'h3,
		// Flush NOP, then turnaround to read mode
		PIPE      = 3'h4,
		// Read pipeline delay and capture
		READ      = 3'h5,
		// Turnaround, desync, release
		DONE      = 3'h6
	} icap_state_t;

endpackage

// File: rtl/icap_idcode_reader.sv
`timescale 1ns/1ps
`include "device_info_params.svh"

module icap_idcode_reader (
	input  logic                           clk_icap,
	input  logic                           rst,

	// ICAP port, byte bit order already swapped
	output logic [`DEVINFO_DATA_WIDTH-1:0] icap_din,
	output logic                           icap_cs_n,
	output logic                           icap_rdwr_n,
	input  logic [`DEVINFO_DATA_WIDTH-1:0] icap_dout,

	// Captured IDCODE, held until reset
	output logic [`DEVINFO_DATA_WIDTH-1:0] idcode,
	output logic                           idcode_valid
);

	////////////////////////////////////////////////////////////
	// Byte-wise bit reversal

	// ICAP wants bit 7 of each byte on bit 0 and so on
	// Same mapping in both directions
	function automatic logic [`DEVINFO_DATA_WIDTH-1:0] bit_reverse_bytes(
		input logic [`DEVINFO_DATA_WIDTH-1:0] word
	);
		logic [`DEVINFO_DATA_WIDTH-1:0] swapped;
		swapped = '0;
		for (int b = 0; b < `DEVINFO_DATA_WIDTH / 8; b++) begin
			for (int g = 0; g < 8; g++) begin
				swapped[b*8 + g] = word[b*8 + 7 - g];
			end
		end
		return swapped;
	endfunction

	////////////////////////////////////////////////////////////
	// Boot hold timer

	localparam int BOOT_W = $clog2(`DEVINFO_BOOT_HOLD + 1);

	logic [BOOT_W-1:0] boot_count;
	logic              boot_done;

	// Counts up once after reset, then parks
	always_ff @(posedge clk_icap) begin
		if (rst) begin
			boot_count <= '0;
			boot_done  <= 1'b0;
		end else if (!boot_done) begin
			boot_count <= boot_count + 1'b1;
			if (boot_count == BOOT_W'(`DEVINFO_BOOT_HOLD - 1))
				boot_done <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// ICAP command sequencer

	device_info_pkg::icap_state_t state;

	// Shared step counter, reused by every state
	logic [3:0] step;

	// Command word in natural bit order
	logic [`DEVINFO_DATA_WIDTH-1:0] din_word;

	// Swap on the way out
	assign icap_din = bit_reverse_bytes(din_word);

	always_ff @(posedge clk_icap) begin
		if (rst) begin
			state        <= device_info_pkg::BOOT_HOLD;
			step         <= '0;
			din_word     <= '1;
			icap_cs_n    <= 1'b1;
			icap_rdwr_n  <= 1'b1;
			idcode       <= '0;
			idcode_valid <= 1'b0;
		end else begin
			case (state)

				// Select in write mode once the timer expires
				// First selected cycle carries the idle all-ones word
				device_info_pkg::BOOT_HOLD: begin
					if (boot_done) begin
						icap_cs_n   <= 1'b0;
						icap_rdwr_n <= 1'b0;
						state       <= device_info_pkg::SYNC;
					end
				end

				// Sync word
				device_info_pkg::SYNC: begin
					din_word <= `ICAP_WORD_SYNC;
					step     <= '0;
					state    <= device_info_pkg::NOP;
				end

				// Two NOPs, input ignored right after sync
				device_info_pkg::NOP: begin
					din_word <= `ICAP_WORD_NOP;
					step     <= step + 1'b1;
					if (step == 4'd1)
						state <= device_info_pkg::HEADER;
				end

				// Ask for one word of IDCODE
				device_info_pkg::HEADER: begin
					din_word <= `ICAP_WORD_RD_IDCODE;
					step     <= '0;
					state    <= device_info_pkg::PIPE;
				end

				// One flush NOP behind the header
				// then deselect, flip to read, reselect
				device_info_pkg::PIPE: begin
					din_word <= `ICAP_WORD_NOP;
					step     <= step + 1'b1;
					if (step == 4'd1)
						icap_cs_n <= 1'b1;
					if (step == 4'd2)
						icap_rdwr_n <= 1'b1;
					if (step == 4'd3) begin
						icap_cs_n <= 1'b0;
						step      <= '0;
						state     <= device_info_pkg::READ;
					end
				end

				// Read data comes out a few clocks late
				device_info_pkg::READ: begin
					step <= step + 1'b1;
					// Capture, unswapped
					if (step == 4'd3)
						idcode <= bit_reverse_bytes(icap_dout);
					// Flag a few clocks after the capture
					if (step == 4'd8) begin
						idcode_valid <= 1'b1;
						step         <= '0;
						state        <= device_info_pkg::DONE;
					end
				end

				// Turn around, desync, then let go of the port
				device_info_pkg::DONE: begin
					// Counter parks at 9
					if (step < 4'd9)
						step <= step + 1'b1;

					// Deselect before changing direction
					if (step == 4'd0)
						icap_cs_n <= 1'b1;
					if (step == 4'd1)
						icap_rdwr_n <= 1'b0;
					if (step == 4'd2) begin
						din_word  <= `ICAP_WORD_NOP;
						icap_cs_n <= 1'b0;
					end

					// Write one word to CMD, the DESYNC command
					if (step == 4'd4)
						din_word <= `ICAP_WORD_WR_CMD;
					if (step == 4'd5)
						din_word <= `ICAP_WORD_DESYNC;

					// Trailing NOPs
					if (step == 4'd6)
						din_word <= `ICAP_WORD_NOP;

					// Released for good
					if (step == 4'd8)
						icap_cs_n <= 1'b1;
				end

				default: begin
					state <= device_info_pkg::BOOT_HOLD;
				end

			endcase
		end
	end

endmodule

// File: rtl/apb_device_info_regs.sv
`timescale 1ns/1ps
`include "device_info_params.svh"

module apb_device_info_regs (
	// APB completer, no wait states
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [`DEVINFO_ADDR_WIDTH-1:0] paddr,
	output logic                           pready,
	output logic [`DEVINFO_DATA_WIDTH-1:0] prdata,
	output logic                           pslverr,

	// From the ICAP reader
	input  logic [`DEVINFO_DATA_WIDTH-1:0] idcode,
	input  logic                           idcode_valid
);

	////////////////////////////////////////////////////////////
	// Read decode

	// Purely combinational, answers in the access phase
	always_comb begin
		pready  = psel && penable;
		prdata  = '0;
		pslverr = 1'b0;

		if (pready) begin

			// Reads
			if (!pwrite) begin
				case (paddr)
					// Valid flag in bit 0
					device_info_pkg::REG_STATUS: begin
						prdata = {{(`DEVINFO_DATA_WIDTH-1){1'b0}}, idcode_valid};
					end
					device_info_pkg::REG_IDCODE: begin
						prdata = idcode;
					end
					// Unmapped offset
					default: begin
						pslverr = 1'b1;
					end
				endcase
			end

			// Nothing here is writable
			else begin
				pslverr = 1'b1;
			end

		end
	end

endmodule

// File: rtl/device_info_top.sv
`timescale 1ns/1ps
`include "device_info_params.svh"

module device_info_top (
	input  logic                           clk_icap,
	input  logic                           rst,

	// APB completer
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [`DEVINFO_ADDR_WIDTH-1:0] paddr,
	input  logic [`DEVINFO_DATA_WIDTH-1:0] pwdata,
	output logic                           pready,
	output logic [`DEVINFO_DATA_WIDTH-1:0] prdata,
	output logic                           pslverr,

	// ICAP, to the primitive or the model
	output logic [`DEVINFO_DATA_WIDTH-1:0] icap_din,
	output logic                           icap_cs_n,
	output logic                           icap_rdwr_n,
	input  logic [`DEVINFO_DATA_WIDTH-1:0] icap_dout
);

	////////////////////////////////////////////////////////////
	// Reader to register block

	logic [`DEVINFO_DATA_WIDTH-1:0] idcode;
	logic                           idcode_valid;

	// Boot hold, ICAP sequence, IDCODE capture
	icap_idcode_reader i_reader (
		.clk_icap     (clk_icap),
		.rst          (rst),
		.icap_din     (icap_din),
		.icap_cs_n    (icap_cs_n),
		.icap_rdwr_n  (icap_rdwr_n),
		.icap_dout    (icap_dout),
		.idcode       (idcode),
		.idcode_valid (idcode_valid)
	);

	// Read-only registers, pwdata has no sink
	apb_device_info_regs i_regs (
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pready       (pready),
		.prdata       (prdata),
		.pslverr      (pslverr),
		.idcode       (idcode),
		.idcode_valid (idcode_valid)
	);

endmodule

// File: sim/icap_model.sv
`timescale 1ns/1ps
`include "device_info_params.svh"

module icap_model (
	input  logic                           clk_icap,
	input  logic                           rst,

	// ICAP pins as seen by the primitive
	input  logic [`DEVINFO_DATA_WIDTH-1:0] icap_din,
	input  logic                           icap_cs_n,
	input  logic                           icap_rdwr_n,
	output logic [`DEVINFO_DATA_WIDTH-1:0] icap_dout,

	// Device IDCODE to hand out, natural bit order
	input  logic [`DEVINFO_DATA_WIDTH-1:0] idcode,

	// Status towards the testbench
	output int                             protocol_errors,
	output logic                           desync_seen
);

	////////////////////////////////////////////////////////////
	// Byte-wise bit swap

	// Bit i pairs with the mirror bit inside the same byte
	function automatic logic [`DEVINFO_DATA_WIDTH-1:0] swap_bits_in_bytes(
		input logic [`DEVINFO_DATA_WIDTH-1:0] w
	);
		logic [`DEVINFO_DATA_WIDTH-1:0] r;
		for (int i = 0; i < `DEVINFO_DATA_WIDTH; i++) begin
			r[i] = w[(i & ~7) | (7 - (i & 7))];
		end
		return r;
	endfunction

	// Where the command stream stands
	device_info_pkg::icap_state_t phase;

	// NOPs seen in the current phase
	int nop_count;
	// Read cycles since the header
	int read_count;
	// IDCODE is driven only between header and desync
	logic armed;

	// Incoming word back in natural order
	logic [`DEVINFO_DATA_WIDTH-1:0] word;

	assign word      = swap_bits_in_bytes(icap_din);
	assign icap_dout = (armed && !icap_cs_n && icap_rdwr_n) ? swap_bits_in_bytes(idcode) : '0;

	task automatic wrong_word(input logic [`DEVINFO_DATA_WIDTH-1:0] expected);
		$display("CHECK FAILED icap_din expected %h actual %h", expected, word);
		protocol_errors <= protocol_errors + 1;
	endtask

	task automatic protocol_fault(input string what);
		$display("ICAP model error: %s", what);
		protocol_errors <= protocol_errors + 1;
	endtask

	// Tally survives resets of the DUT
	initial protocol_errors = 0;

	////////////////////////////////////////////////////////////
	// Command stream checker

	always @(posedge clk_icap) begin
		if (rst) begin
			phase       <= device_info_pkg::BOOT_HOLD;
			nop_count   <= 0;
			read_count  <= 0;
			armed       <= 1'b0;
			desync_seen <= 1'b0;
		end else if (!icap_cs_n && !icap_rdwr_n) begin
			case (phase)
				// Dummy all-ones words allowed ahead of sync
				device_info_pkg::BOOT_HOLD: begin
					if (word == `ICAP_WORD_SYNC)
						phase <= device_info_pkg::SYNC;
					else if (word != '1)
						wrong_word(`ICAP_WORD_SYNC);
				end
				// Exactly two NOPs after sync
				device_info_pkg::SYNC: begin
					if (word != `ICAP_WORD_NOP) begin
						wrong_word(`ICAP_WORD_NOP);
					end else begin
						nop_count <= nop_count + 1;
						if (nop_count == 1)
							phase <= device_info_pkg::HEADER;
					end
				end
				device_info_pkg::HEADER: begin
					if (word == `ICAP_WORD_RD_IDCODE) begin
						phase     <= device_info_pkg::PIPE;
						armed     <= 1'b1;
						nop_count <= 0;
					end else begin
						wrong_word(`ICAP_WORD_RD_IDCODE);
					end
				end
				// Flush NOPs behind the header
				device_info_pkg::PIPE: begin
					if (word == `ICAP_WORD_NOP)
						nop_count <= nop_count + 1;
					else
						wrong_word(`ICAP_WORD_NOP);
				end
				// After the read, NOPs then the CMD write header
				device_info_pkg::READ: begin
					if (word == `ICAP_WORD_WR_CMD) begin
						phase <= device_info_pkg::DONE;
						if (read_count < 4)
							protocol_fault("CMD write came before the read data was out");
					end else if (word != `ICAP_WORD_NOP) begin
						wrong_word(`ICAP_WORD_WR_CMD);
					end
				end
				// DESYNC once, then only NOPs
				default: begin
					if (!desync_seen && word == `ICAP_WORD_DESYNC) begin
						desync_seen <= 1'b1;
						armed       <= 1'b0;
					end else if (!desync_seen) begin
						wrong_word(`ICAP_WORD_DESYNC);
					end else if (word != `ICAP_WORD_NOP) begin
						wrong_word(`ICAP_WORD_NOP);
					end
				end
			endcase
		end else if (!icap_cs_n) begin
			// Read cycle
			if (phase == device_info_pkg::PIPE && nop_count > 0) begin
				phase      <= device_info_pkg::READ;
				read_count <= 1;
			end else if (phase == device_info_pkg::READ) begin
				read_count <= read_count + 1;
			end else begin
				protocol_fault("read cycle outside the IDCODE read window");
			end
		end
	end

endmodule

// File: sim/device_info_sva.sv
`timescale 1ns/1ps
`include "device_info_params.svh"

module device_info_sva (
	input logic                           clk_icap,
	input logic                           rst,
	input logic                           psel,
	input logic                           penable,
	input logic                           pready,
	input logic                           pslverr,
	input logic [`DEVINFO_DATA_WIDTH-1:0] icap_din,
	input logic                           icap_cs_n,
	input logic                           icap_rdwr_n
);

	// Failure tally, picked up by the testbench
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// ICAP side

	// Command word parked while the port is released
	a_din_stable: assert property (@(posedge clk_icap) disable iff (rst)
		(icap_cs_n && $past(icap_cs_n)) |-> $stable(icap_din))
	else begin
		fail_count++;
		$error("icap_din moved while chip select was released");
	end

	// Direction flips only out of a released cycle
	a_rdwr_turnaround: assert property (@(posedge clk_icap) disable iff (rst)
		!$stable(icap_rdwr_n) |-> $past(icap_cs_n))
	else begin
		fail_count++;
		$error("icap_rdwr_n changed while chip select was active");
	end

	////////////////////////////////////////////////////////////
	// APB side

	// Zero wait states
	a_pready_follows: assert property (@(posedge clk_icap) disable iff (rst)
		pready == (psel && penable))
	else begin
		fail_count++;
		$error("pready does not follow psel and penable");
	end

	a_slverr_with_ready: assert property (@(posedge clk_icap) disable iff (rst)
		pslverr |-> pready)
	else begin
		fail_count++;
		$error("pslverr raised outside the access phase");
	end

endmodule

bind device_info_top device_info_sva i_sva (
	.clk_icap    (clk_icap),
	.rst         (rst),
	.psel        (psel),
	.penable     (penable),
	.pready      (pready),
	.pslverr     (pslverr),
	.icap_din    (icap_din),
	.icap_cs_n   (icap_cs_n),
	.icap_rdwr_n (icap_rdwr_n)
);

// File: sim/device_info_tb.sv
`timescale 1ns/1ps
`include "device_info_params.svh"

module device_info_tb;

	localparam int AW              = `DEVINFO_ADDR_WIDTH;
	localparam int DW              = `DEVINFO_DATA_WIDTH;
	localparam int APB_TIMEOUT     = 16;
	localparam int POLL_LIMIT      = 64;
	localparam int DESYNC_TIMEOUT  = 400;
	localparam int RANDOM_ACCESSES = 24;

	logic          clk_icap;
	logic          rst;
	logic          psel;
	logic          penable;
	logic          pwrite;
	logic [AW-1:0] paddr;
	logic [DW-1:0] pwdata;
	logic          pready;
	logic [DW-1:0] prdata;
	logic          pslverr;
	logic [DW-1:0] icap_din;
	logic          icap_cs_n;
	logic          icap_rdwr_n;
	logic [DW-1:0] icap_dout;

	// ICAP model hookup
	logic [DW-1:0] model_idcode;
	int            model_errors;
	logic          desync_seen;

	logic [31:0]   lfsr_state;
	logic [DW-1:0] run_id;
	int            errors;
	int            timeouts;

	device_info_top i_dut (
		.clk_icap (clk_icap), .rst (rst),
		.psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
		.pwdata (pwdata), .pready (pready), .prdata (prdata), .pslverr (pslverr),
		.icap_din (icap_din), .icap_cs_n (icap_cs_n), .icap_rdwr_n (icap_rdwr_n),
		.icap_dout (icap_dout)
	);

	icap_model i_icap (
		.clk_icap (clk_icap), .rst (rst),
		.icap_din (icap_din), .icap_cs_n (icap_cs_n), .icap_rdwr_n (icap_rdwr_n),
		.icap_dout (icap_dout), .idcode (model_idcode),
		.protocol_errors (model_errors), .desync_seen (desync_seen)
	);

	// 8 ns period
	always #4 clk_icap = ~clk_icap;

	////////////////////////////////////////////////////////////
	// Random source

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit, LSB out
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v          = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model and helpers

	// {pslverr, prdata} for one access
	function automatic logic [DW:0] expected_response(input logic wr, input logic [AW-1:0] addr,
			input logic valid, input logic [DW-1:0] id);
		if (wr)
			return {1'b1, {DW{1'b0}}};
		if (addr == device_info_pkg::REG_STATUS)
			return {1'b0, {(DW-1){1'b0}}, valid};
		if (addr == device_info_pkg::REG_IDCODE)
			return {1'b0, id};
		return {1'b1, {DW{1'b0}}};
	endfunction

	task automatic report_mismatch(input string name, input logic [DW-1:0] exp,
			input logic [DW-1:0] act);
		$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		errors++;
	endtask

	// Reset held 5 cycles, model gets its new IDCODE meanwhile
	task automatic apply_reset(input logic [DW-1:0] id);
		@(posedge clk_icap);
		rst          <= 1'b1;
		psel         <= 1'b0;
		penable      <= 1'b0;
		model_idcode <= id;
		repeat (5) @(posedge clk_icap);
		rst <= 1'b0;
	endtask

	// Setup then access phase, sampled on the falling edge
	task automatic apb_transfer(input logic wr, input logic [AW-1:0] addr,
			input logic [DW-1:0] wdata, output logic [DW-1:0] rdata, output logic slverr);
		int waited;
		@(posedge clk_icap);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk_icap);
		penable <= 1'b1;
		waited = 0;
		@(negedge clk_icap);
		while (!pready && waited < APB_TIMEOUT) begin
			@(negedge clk_icap);
			waited++;
		end
		if (!pready) begin
			timeouts++;
			$display("APB access to offset %h never saw pready", addr);
		end
		rdata  = prdata;
		slverr = pslverr;
		@(posedge clk_icap);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Boot sequence, valid flag, IDCODE, desync

	task automatic run_boot_check(input logic [DW-1:0] id);
		logic [DW-1:0] rdata;
		logic          slverr;
		int            polls;
		// Still in the boot hold, nothing captured
		apb_transfer(1'b0, device_info_pkg::REG_STATUS, '0, rdata, slverr);
		if (rdata !== '0)
			report_mismatch("prdata", '0, rdata);
		if (slverr !== 1'b0)
			report_mismatch("pslverr", 0, slverr);
		apb_transfer(1'b0, device_info_pkg::REG_IDCODE, '0, rdata, slverr);
		if (rdata !== '0)
			report_mismatch("prdata", '0, rdata);
		if (slverr !== 1'b0)
			report_mismatch("pslverr", 0, slverr);

		// Poll until the flag shows up
		polls = 0;
		rdata = '0;
		while (rdata[0] !== 1'b1 && polls < POLL_LIMIT) begin
			apb_transfer(1'b0, device_info_pkg::REG_STATUS, '0, rdata, slverr);
			polls++;
		end
		if (rdata[0] !== 1'b1) begin
			timeouts++;
			$display("Status register never reported a valid IDCODE");
		end else begin
			if (rdata !== 1)
				report_mismatch("prdata", 1, rdata);
			apb_transfer(1'b0, device_info_pkg::REG_IDCODE, '0, rdata, slverr);
			if (rdata !== id)
				report_mismatch("prdata", id, rdata);
			if (slverr !== 1'b0)
				report_mismatch("pslverr", 0, slverr);
		end

		// Desync closes the ICAP session
		polls = 0;
		while (!desync_seen && polls < DESYNC_TIMEOUT) begin
			@(negedge clk_icap);
			polls++;
		end
		if (!desync_seen) begin
			timeouts++;
			$display("ICAP model never received the DESYNC command");
		end
	endtask

	// Unmapped reads and writes all fault, IDCODE untouched
	task automatic random_access_check(input logic [DW-1:0] id);
		logic [31:0]   bits;
		logic          wr;
		logic [AW-1:0] addr;
		logic [DW-1:0] wdata;
		logic [DW-1:0] rdata;
		logic          slverr;
		logic [DW:0]   exp;
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			take_bits(1, bits);
			wr = bits[0];
			take_bits(AW, bits);
			addr = bits[AW-1:0];
			take_bits(DW, bits);
			wdata = bits;
			// Push reads off the two mapped words
			if (!wr && (addr == 0 || addr == 4))
				addr = addr ^ 8'h10;
			exp = expected_response(wr, addr, 1'b1, id);
			apb_transfer(wr, addr, wdata, rdata, slverr);
			if (slverr !== exp[DW])
				report_mismatch("pslverr", exp[DW], slverr);
			if (rdata !== exp[DW-1:0])
				report_mismatch("prdata", exp[DW-1:0], rdata);
		end
		apb_transfer(1'b0, device_info_pkg::REG_IDCODE, '0, rdata, slverr);
		if (rdata !== id)
			report_mismatch("prdata", id, rdata);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		clk_icap     = 1'b0;
		rst          = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		model_idcode = '0;
		errors       = 0;
		timeouts     = 0;
		lfsr_state   = 32'd85;

		// First boot
		take_bits(DW, run_id);
		apply_reset(run_id);
		run_boot_check(run_id);
		random_access_check(run_id);

		// Reset mid-run, fresh IDCODE
		take_bits(DW, run_id);
		apply_reset(run_id);
		run_boot_check(run_id);

		$display("Done: %0d mismatches, %0d timeouts, %0d ICAP protocol, %0d assertion",
			errors, timeouts, model_errors, i_dut.i_sva.fail_count);
		if (errors == 0 && timeouts == 0 && model_errors == 0 && i_dut.i_sva.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: device_info.f
+incdir+rtl
rtl/device_info_pkg.sv
rtl/icap_idcode_reader.sv
rtl/apb_device_info_regs.sv
rtl/device_info_top.sv
sim/icap_model.sv
sim/device_info_sva.sv
sim/device_info_tb.sv

// File: Bender.yml
package:
  name: device_info

sources:
  # Synthesizable design
  - include_dirs:
      - rtl
    files:
      - rtl/device_info_pkg.sv
      - rtl/icap_idcode_reader.sv
      - rtl/apb_device_info_regs.sv
      - rtl/device_info_top.sv

  # Simulation only: ICAP model, assertions, testbench
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/icap_model.sv
      - sim/device_info_sva.sv
      - sim/device_info_tb.sv
